/* files.f */
src/sa_types_pkg.sv
src/chan_cfg_pkg.sv
src/sa_ctrl.sv
src/mac_array.sv
src/chan_param_table.sv
src/requant.sv
src/conv_tile_top.sv
verif/tb_conv_tile.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the conv tile testbench with Verilator.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_conv_tile \
  -Mdir obj_dir -o tb_conv_tile
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_conv_tile
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished"
exit 0

/* src/chan_cfg_pkg.sv */
package chan_cfg_pkg;

  // Largest legal right shift
  localparam int SHIFT_MAX = 31;
  localparam int SHIFT_W   = $clog2(SHIFT_MAX + 1);

  // Per-channel requantization parameters
  typedef struct packed {
    logic signed [31:0]  bias;    // Same shape as acc_t
    logic [SHIFT_W-1:0]  shift;
  } chan_param_t;

  // Reset value of a table entry
  localparam chan_param_t PARAM_ZERO = '{bias: '0, shift: '0};

endpackage

/* src/chan_param_table.sv */
`timescale 1ns/1ps

module chan_param_table
  import sa_types_pkg::*;
  import chan_cfg_pkg::*;
#(
  parameter int N_ROWS = 4
)
(
  input  logic        clk,
  input  logic        reset,
  input  logic        cfg_we,
  input  row_t        cfg_row,
  input  chan_param_t cfg_param,
  input  drain_ctl_t  drain_ctl,
  output chan_param_t param_out
);

  localparam int ROW_W = (N_ROWS > 1) ? $clog2(N_ROWS) : 1;

  chan_param_t      entry [N_ROWS];
  logic [ROW_W-1:0] rd_idx;

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < N_ROWS; i++)
    begin
      if (reset)
        entry[i] <= PARAM_ZERO;
      else if (cfg_we && (cfg_row == row_t'(i)))
        entry[i] <= cfg_param;
    end
  end

  assign rd_idx = drain_ctl.row[ROW_W-1:0];

  always_ff @(posedge clk)
  begin
    if (drain_ctl.valid)
      param_out <= entry[rd_idx];   // Lines up with acc_out
  end

endmodule

/* src/conv_tile_top.sv */
`timescale 1ns/1ps

module conv_tile_top
  import sa_types_pkg::*;
  import chan_cfg_pkg::*;
#(
  parameter int N_ROWS = 4   // Output channels, 1 to 64
)
(
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  len_t              tile_len,
  input  logic              relu_en,
  input  act_t              act_in,
  input  wgt_t [N_ROWS-1:0] wgt_in,
  input  logic              cfg_we,
  input  row_t              cfg_row,
  input  chan_param_t       cfg_param,
  output logic              busy,
  output logic              out_valid,
  output row_t              out_row,
  output q_t                out_data,
  output logic              tile_done
);

  logic        feed_en;
  logic        clear;
  drain_ctl_t  drain_ctl;
  quant_ctl_t  quant_ctl;
  acc_t        acc_out;
  chan_param_t param_out;

  ////////////////////////////////////////////////////////////////////////////
  // Control and the two readout blocks
  ////////////////////////////////////////////////////////////////////////////

  sa_ctrl #(.N_ROWS(N_ROWS)) ctrl0 (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .tile_len  (tile_len),
    .relu_en   (relu_en),
    .feed_en   (feed_en),
    .clear     (clear),
    .busy      (busy),
    .drain_ctl (drain_ctl),
    .quant_ctl (quant_ctl)
  );

  mac_array #(.N_ROWS(N_ROWS)) mac0 (
    .clk       (clk),
    .reset     (reset),
    .feed_en   (feed_en),
    .clear     (clear),
    .act_in    (act_in),
    .wgt_in    (wgt_in),
    .drain_ctl (drain_ctl),
    .acc_out   (acc_out)
  );

  chan_param_table #(.N_ROWS(N_ROWS)) table0 (
    .clk       (clk),
    .reset     (reset),
    .cfg_we    (cfg_we),
    .cfg_row   (cfg_row),
    .cfg_param (cfg_param),
    .drain_ctl (drain_ctl),
    .param_out (param_out)
  );

  // Output stage
  requant quant0 (
    .clk       (clk),
    .reset     (reset),
    .quant_ctl (quant_ctl),
    .acc_in    (acc_out),
    .param_in  (param_out),
    .out_valid (out_valid),
    .out_row   (out_row),
    .out_data  (out_data),
    .tile_done (tile_done)
  );

endmodule

/* src/mac_array.sv */
`timescale 1ns/1ps

module mac_array
  import sa_types_pkg::*;
#(
  parameter int N_ROWS = 4
)
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    feed_en,
  input  logic                    clear,
  input  act_t                    act_in,
  input  wgt_t [N_ROWS-1:0]       wgt_in,
  input  drain_ctl_t              drain_ctl,
  output acc_t                    acc_out
);

  localparam int ROW_W = (N_ROWS > 1) ? $clog2(N_ROWS) : 1;

  acc_t             prod [N_ROWS];
  acc_t             acc  [N_ROWS];
  logic [ROW_W-1:0] rd_idx;

  // One product per channel, same activation across the column
  always_comb
  begin
    for (int i = 0; i < N_ROWS; i++)
      prod[i] = acc_t'(act_in) * acc_t'(wgt_in[i]);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Channel accumulators
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < N_ROWS; i++)
    begin
      if (reset)
        acc[i] <= '0;
      else if (clear)
        acc[i] <= prod[i];            // First word of a tile
      else if (feed_en)
        acc[i] <= acc[i] + prod[i];   // Wraps at 32 bits
    end
  end

  assign rd_idx = drain_ctl.row[ROW_W-1:0];

  // Drain readout, one channel per step
  always_ff @(posedge clk)
  begin
    if (drain_ctl.valid)
      acc_out <= acc[rd_idx];
  end

endmodule

/* src/requant.sv */
`timescale 1ns/1ps

module requant
  import sa_types_pkg::*;
  import chan_cfg_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  quant_ctl_t  quant_ctl,
  input  acc_t        acc_in,
  input  chan_param_t param_in,
  output logic        out_valid,
  output row_t        out_row,
  output q_t          out_data,
  output logic        tile_done
);

  logic signed [32:0] sum;
  logic signed [32:0] shifted;
  logic signed [32:0] rectified;
  q_t                 sat;

  ////////////////////////////////////////////////////////////////////////////
  // Bias, shift, ReLU, clamp
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    sum     = 33'(acc_in) + 33'(param_in.bias);   // One guard bit, no overflow
    shifted = sum >>> param_in.shift;             // Floor toward minus infinity
    if (quant_ctl.relu && (shifted < 0))
      rectified = '0;
    else
      rectified = shifted;
    if (rectified > 33'sd127)
      sat = 8'sd127;
    else if (rectified < -33'sd128)
      sat = -8'sd128;
    else
      sat = rectified[7:0];
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      out_valid <= 1'b0;
      tile_done <= 1'b0;
    end
    else
    begin
      out_valid <= quant_ctl.drain.valid;
      tile_done <= quant_ctl.drain.last;
    end
  end

  // Payload rides along with the strobes
  always_ff @(posedge clk)
  begin
    out_row  <= quant_ctl.drain.row;
    out_data <= sat;
  end

endmodule

/* src/sa_ctrl.sv */
`timescale 1ns/1ps

module sa_ctrl
  import sa_types_pkg::*;
#(
  parameter int N_ROWS = 4
)
(
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  input  len_t       tile_len,
  input  logic       relu_en,
  output logic       feed_en,
  output logic       clear,
  output logic       busy,
  output drain_ctl_t drain_ctl,
  output quant_ctl_t quant_ctl
);

  localparam int ROW_W = (N_ROWS > 1) ? $clog2(N_ROWS) : 1;

  logic             start_ok;
  len_t             len_q;
  logic             relu_q;
  logic             feed_run;
  len_t             feed_cnt;
  len_t             cur_len;
  len_t             cur_idx;
  logic             feed_last;
  logic             drain_run;
  logic [ROW_W-1:0] drain_row;
  logic             drain_last;

  assign busy     = feed_run || drain_run;
  assign start_ok = start && !busy;   // Starts while busy are dropped

  // Tile settings, held for the whole tile
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      len_q  <= '0;
      relu_q <= 1'b0;
    end
    else if (start_ok)
    begin
      len_q  <= tile_len;
      relu_q <= relu_en;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Feed phase, cycles 0 to L-1
  ////////////////////////////////////////////////////////////////////////////

  assign cur_len   = start_ok ? tile_len : len_q;   // Cycle 0 sees the live length
  assign cur_idx   = start_ok ? '0 : feed_cnt;
  assign feed_en   = start_ok || feed_run;
  assign clear     = start_ok;
  assign feed_last = feed_en && (cur_idx == cur_len - 8'd1);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      feed_run <= 1'b0;
      feed_cnt <= '0;
    end
    else if (feed_en)
    begin
      feed_run <= !feed_last;
      feed_cnt <= feed_last ? '0 : cur_idx + 8'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Drain phase, row r in cycle L+r
  ////////////////////////////////////////////////////////////////////////////

  assign drain_last = drain_run && (drain_row == ROW_W'(N_ROWS - 1));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      drain_run <= 1'b0;
      drain_row <= '0;
    end
    else if (feed_last)
    begin
      drain_run <= 1'b1;
      drain_row <= '0;
    end
    else if (drain_run)
    begin
      drain_run <= !drain_last;
      drain_row <= drain_last ? '0 : drain_row + 1'b1;
    end
  end

  always_comb
  begin
    drain_ctl.valid = drain_run;
    drain_ctl.row   = row_t'(drain_row);
    drain_ctl.last  = drain_last;
  end

  // Stage enable for the requantizer, lines up with the registered reads
  always_ff @(posedge clk)
  begin
    if (reset)
      quant_ctl <= '0;
    else
    begin
      quant_ctl.drain <= drain_ctl;
      quant_ctl.relu  <= relu_q;
    end
  end

endmodule

/* src/sa_types_pkg.sv */
package sa_types_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data-path words
  ////////////////////////////////////////////////////////////////////////////

  typedef logic signed [7:0]  act_t;   // Activation
  typedef logic signed [7:0]  wgt_t;   // Weight
  typedef logic signed [31:0] acc_t;   // Accumulator, wraps
  typedef logic signed [7:0]  q_t;     // Requantized output
  typedef logic        [7:0]  len_t;   // Tile length, 1 to 255
  typedef logic        [7:0]  row_t;   // Channel index

  ////////////////////////////////////////////////////////////////////////////
  // Controller strobes
  ////////////////////////////////////////////////////////////////////////////

  // Drain step, to MAC array and parameter table
  typedef struct packed {
    logic valid;
    row_t row;
    logic last;
  } drain_ctl_t;

  // Drain step one cycle later, to the requantizer
  typedef struct packed {
    drain_ctl_t drain;
    logic       relu;
  } quant_ctl_t;

endpackage

/* verif/tb_conv_tile.sv */
`timescale 1ns/1ps

module tb_conv_tile
  import sa_types_pkg::*;
  import chan_cfg_pkg::*;
();

  localparam int N_ROWS  = 4;
  localparam int N_TESTS = 8;
  localparam logic [1:0] PAT_RAND = 2'd0;   // Random words
  localparam logic [1:0] PAT_POS  = 2'd1;   // 127 times 127 on every word
  localparam logic [1:0] PAT_NEG  = 2'd2;   // -128 times 127 on every word

  typedef struct packed {
    len_t                     len;
    logic                     relu;
    logic [1:0]               kind;
    chan_param_t [0:N_ROWS-1] prm;
    logic                     b2b;    // Start right as the previous tile leaves busy
  } tile_t;

  typedef struct {
    row_t row;
    q_t   data;
    logic done;
    int   due;    // Cycle in which the row must appear
  } exp_t;

  logic              clk;
  logic              reset;
  logic              start;
  len_t              tile_len;
  logic              relu_en;
  act_t              act_in;
  wgt_t [N_ROWS-1:0] wgt_in;
  logic              cfg_we;
  row_t              cfg_row;
  chan_param_t       cfg_param;
  logic              busy;
  logic              out_valid;
  row_t              out_row;
  q_t                out_data;
  logic              tile_done;

  tile_t       tbl [N_TESTS];
  chan_param_t cur_prm [N_ROWS];   // Mirror of the DUT table
  exp_t        exp_q [$];
  int          cyc = 0;
  int          busy_lo = 0;        // First and last cycle of the busy window
  int          busy_hi = -1;

  conv_tile_top #(.N_ROWS(N_ROWS)) dut0 (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .tile_len  (tile_len),
    .relu_en   (relu_en),
    .act_in    (act_in),
    .wgt_in    (wgt_in),
    .cfg_we    (cfg_we),
    .cfg_row   (cfg_row),
    .cfg_param (cfg_param),
    .busy      (busy),
    .out_valid (out_valid),
    .out_row   (out_row),
    .out_data  (out_data),
    .tile_done (tile_done)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  function automatic chan_param_t mk_param(input int bias, input int shift);
    chan_param_t p;
    if (shift > SHIFT_MAX)
      shift = SHIFT_MAX;
    p.bias  = bias;
    p.shift = SHIFT_W'(shift);
    return p;
  endfunction

  // Bias, floor shift, optional ReLU, clamp to int8
  function automatic q_t requant_ref(input int acc, input chan_param_t p, input logic relu);
    longint s;
    s = longint'(acc) + longint'(p.bias);
    s = s >>> p.shift;
    if (relu && (s < 0))
      s = 0;
    if (s > 127)
      return q_t'(127);
    else if (s < -128)
      return q_t'(-128);
    else
      return q_t'(s);
  endfunction

  task automatic stop_run(input string why);
    $display("*** FAILED ***");
    $fatal(1, "%s", why);
  endtask

  task automatic check_q(input string name, input q_t got, input q_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
      stop_run("Requantized output differs from the model");
    end
  endtask

  task automatic check_row(input string name, input row_t got, input row_t exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
      stop_run("Output row index differs from the model");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
      stop_run("Strobe level differs from the model");
    end
  endtask

  // Checked on the falling edge between driving edges
  task automatic check_outputs();
    exp_t e;
    logic due_now;
    due_now = (exp_q.size() != 0) && (exp_q[0].due == cyc);
    check_bit("busy", busy, (cyc >= busy_lo) && (cyc <= busy_hi));
    check_bit("out_valid", out_valid, due_now);
    if (due_now)
    begin
      e = exp_q.pop_front();
      check_row("out_row", out_row, e.row);
      check_q("out_data", out_data, e.data);
      check_bit("tile_done", tile_done, e.done);
    end
    else
      check_bit("tile_done", tile_done, 1'b0);
  endtask

  always @(negedge clk)
  begin
    if (!reset)
      check_outputs();
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_table();
    tbl[0] = '{len: 8'd5, relu: 1'b0, kind: PAT_RAND, b2b: 1'b0,
               prm: '{mk_param(0, 0), mk_param(100, 2), mk_param(-50, 1), mk_param(0, 4)}};
    tbl[1] = '{len: 8'd8, relu: 1'b1, kind: PAT_RAND, b2b: 1'b1, prm: tbl[0].prm};
    tbl[2] = '{len: 8'd200, relu: 1'b0, kind: PAT_POS, b2b: 1'b0,
               prm: '{mk_param(0, 0), mk_param(0, 10), mk_param(-3000000, 14),
                      mk_param(0, 20)}};
    tbl[3] = '{len: 8'd200, relu: 1'b1, kind: PAT_NEG, b2b: 1'b1, prm: tbl[2].prm};
    tbl[4] = '{len: 8'd255, relu: 1'b0, kind: PAT_NEG, b2b: 1'b0,
               prm: '{mk_param(0, 0), mk_param(0, 20), mk_param(5000000, 14),
                      mk_param(0, SHIFT_MAX)}};
    tbl[5] = '{len: 8'd1, relu: 1'b1, kind: PAT_RAND, b2b: 1'b0,
               prm: '{mk_param(-5, 0), mk_param(5, 0), mk_param(0, 1), mk_param(127, 0)}};
    tbl[6] = '{len: 8'd37, relu: 1'b0, kind: PAT_RAND, b2b: 1'b1, prm: tbl[5].prm};
    tbl[7] = '{len: 8'd60, relu: 1'b1, kind: PAT_POS, b2b: 1'b0,
               prm: '{mk_param(-1000000, 0), mk_param(0, 13), mk_param(-967740, 3),
                      mk_param(100, 31)}};
  endtask

  task automatic run_tile(input tile_t tc);
    act_t              acts [256];
    wgt_t [N_ROWS-1:0] wgts [256];
    int                acc [N_ROWS];
    int                len;
    int                base;
    exp_t              e;
    len = int'(tc.len);
    for (int i = 0; i < N_ROWS; i++)
      acc[i] = 0;
    for (int c = 0; c < len; c++)
    begin
      acts[c] = (tc.kind == PAT_POS) ? act_t'(127) :
                (tc.kind == PAT_NEG) ? act_t'(-128) : act_t'($urandom);
      for (int i = 0; i < N_ROWS; i++)
      begin
        wgts[c][i] = (tc.kind == PAT_RAND) ? wgt_t'($urandom) : wgt_t'(127);
        acc[i] += int'(acts[c]) * int'(wgts[c][i]);   // 32-bit wrap
      end
    end
    if (!tc.b2b)
    begin
      for (int i = 0; i < N_ROWS; i++)
      begin
        @(posedge clk);
        cfg_we     <= 1'b1;
        cfg_row    <= row_t'(i);
        cfg_param  <= tc.prm[i];
        cur_prm[i] = tc.prm[i];
      end
    end
    for (int c = 0; c < len + N_ROWS; c++)
    begin
      @(posedge clk);
      if (c == 0)
      begin
        base    = cyc + 1 + len + 2;   // Row 0 lands in cycle L+2
        busy_lo = cyc + 2;
        busy_hi = cyc + len + N_ROWS;
        for (int r = 0; r < N_ROWS; r++)
        begin
          e.row  = row_t'(r);
          e.data = requant_ref(acc[r], cur_prm[r], tc.relu);
          e.done = (r == N_ROWS - 1);
          e.due  = base + r;
          exp_q.push_back(e);
        end
      end
      cfg_we   <= 1'b0;
      start    <= (c < 2);                            // Second pulse hits busy
      tile_len <= (c == 0) ? tc.len : 8'd3;
      relu_en  <= (c == 0) ? tc.relu : !tc.relu;
      if (c < len)
      begin
        act_in <= acts[c];
        wgt_in <= wgts[c];
      end
      else
      begin
        act_in <= act_t'($urandom);   // Ignored outside the feed phase
        wgt_in <= $urandom;
      end
    end
  endtask

  initial
  begin
    void'($urandom(32'h7dc35227));
    reset     = 1'b1;
    start     = 1'b0;
    tile_len  = '0;
    relu_en   = 1'b0;
    act_in    = '0;
    wgt_in    = '0;
    cfg_we    = 1'b0;
    cfg_row   = '0;
    cfg_param = '0;
    for (int i = 0; i < N_ROWS; i++)
      cur_prm[i] = '0;
    fill_table();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    repeat (3) @(posedge clk);
    for (int t = 0; t < N_TESTS; t++)
      run_tile(tbl[t]);
    repeat (N_ROWS + 8) @(negedge clk);
    if (exp_q.size() == 0)
    begin
      $display("*** PASSED ***");
      $finish;
    end
    else
    begin
      $display("*** FAILED ***");
      $fatal(1, "Expected output rows never arrived");
    end
  end

  // Watchdog sized from the table
  initial
  begin
    int limit;
    #1;
    limit = 100;
    for (int t = 0; t < N_TESTS; t++)
      limit += int'(tbl[t].len) + 4 + 10;
    repeat (limit) @(posedge clk);
    $display("*** FAILED ***");
    $fatal(1, "Timeout, the run did not finish within %0d cycles", limit);
  end

endmodule
